// ==== logic/phold_consts.svh ====
`ifndef PHOLD_CONSTS_SVH
`define PHOLD_CONSTS_SVH

// core array size and core index
`define PH_NUM_CORE     4
`define PH_NB_COREID    2

// logical process id and timestamp widths
`define PH_NB_LPID      6
`define PH_TIME_WID     16

// event queue depth and its count width
`define PH_QUEUE_DEPTH  16
`define PH_NB_QCNT      5

// lp id + timestamp + live flag
`define PH_MSG_WID      23

`endif

// ==== logic/phold_pkg.sv ====
`include "phold_consts.svh"

package phold_pkg;

   // event view, live is 0 for an anti-message
   typedef struct packed {
      logic [`PH_NB_LPID-1:0]  target_lp;
      logic [`PH_TIME_WID-1:0] timestamp;
      logic                    live;
   } event_view_t;

   // ordering view: timestamp above the live bit, so anti sorts first at equal time
   typedef struct packed {
      logic [`PH_NB_LPID-1:0] target_lp;
      logic [`PH_TIME_WID:0]  sort_key;
   } sort_view_t;

   // all-zero word is the null message
   typedef union packed {
      event_view_t evt;
      sort_view_t  srt;
   } event_word_u;

endpackage

// ==== logic/queue_port_if.sv ====
interface queue_port_if;

   logic                   enq;
   phold_pkg::event_word_u enq_word;
   logic                   deq;
   phold_pkg::event_word_u head_word;
   logic                   full;
   logic                   empty;

   modport ctrl (
      output enq, enq_word, deq,
      input  head_word, full, empty
   );

   modport queue (
      input  enq, enq_word, deq,
      output head_word, full, empty
   );

   modport monitor (
      input enq, enq_word, deq, head_word, full, empty
   );

endinterface

// ==== logic/rr_arbiter.sv ====
module rr_arbiter #(
   parameter int NR = 4
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [NR-1:0]         req,
   input  logic                  accept,
   output logic                  gnt_vld,
   output logic [$clog2(NR)-1:0] gnt_idx,
   output logic [NR-1:0]         gnt_onehot
);

   localparam int IW = $clog2(NR);

   // highest priority index
   logic [IW-1:0] ptr;

   // first requester at or after the pointer
   always_comb begin
      int unsigned k;
      gnt_vld = 1'b0;
      gnt_idx = '0;
      for (int unsigned i = 0; i < NR; i++) begin
         k = (32'(ptr) + i) % NR;
         if (!gnt_vld && req[k]) begin
            gnt_vld = 1'b1;
            gnt_idx = IW'(k);
         end
      end
   end

   assign gnt_onehot = gnt_vld ? ({{(NR-1){1'b0}}, 1'b1} << gnt_idx) : '0;

   // winner drops to lowest priority once served
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ptr <= '0;
      end else if (accept && gnt_vld) begin
         ptr <= (32'(gnt_idx) == NR - 1) ? '0 : gnt_idx + 1'b1;
      end
   end

endmodule

// ==== logic/event_queue.sv ====
`include "phold_consts.svh"

module event_queue (
   input logic         clk,
   input logic         rst_n,
   queue_port_if.queue q
);

   localparam int DEPTH = `PH_QUEUE_DEPTH;
   localparam logic [`PH_NB_QCNT-1:0] FULL_CNT = `PH_QUEUE_DEPTH;

   // sorted by sort key, smallest in slot 0
   phold_pkg::event_word_u entry [DEPTH];
   phold_pkg::event_word_u prev_word [DEPTH];
   logic [DEPTH-1:0]       after_new;
   logic [`PH_NB_QCNT-1:0] count;
   logic                   do_enq;
   logic                   do_deq;

   assign do_enq = q.enq && !q.full;
   assign do_deq = q.deq && !q.empty;

   // slots at or behind the insertion point
   // equal keys stay ahead of the new word
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         after_new[i] = (i >= int'(count)) ||
                        (entry[i].srt.sort_key > q.enq_word.srt.sort_key);
      end
   end

   // value each slot takes on insert, either the new word or its neighbour
   always_comb begin
      prev_word[0] = q.enq_word;
      for (int i = 1; i < DEPTH; i++) begin
         prev_word[i] = after_new[i-1] ? entry[i-1] : q.enq_word;
      end
   end

   always_ff @(posedge clk) begin
      if (do_enq) begin
         for (int i = 0; i < DEPTH; i++) begin
            if (after_new[i]) begin
               entry[i] <= prev_word[i];
            end
         end
      end else if (do_deq) begin
         // pop head, everything moves forward
         for (int i = 0; i < DEPTH - 1; i++) begin
            entry[i] <= entry[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (do_enq) begin
         count <= count + 1'b1;
      end else if (do_deq) begin
         count <= count - 1'b1;
      end
   end

   assign q.head_word = entry[0];
   assign q.full      = (count == FULL_CNT);
   assign q.empty     = (count == '0);

endmodule

// ==== logic/sim_controller.sv ====
`include "phold_consts.svh"

module sim_controller (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [`PH_TIME_WID-1:0]             sim_end,
   input  logic [7:0]                          num_init_events,
   input  logic [`PH_NB_LPID-1:0]              lp_mask,
   input  logic [`PH_TIME_WID-1:0]             gvt,
   input  logic                                rcv_gnt_vld,
   input  logic [`PH_NB_COREID-1:0]            rcv_gnt_idx,
   input  logic [`PH_NUM_CORE*`PH_MSG_WID-1:0] core_evt_word,
   input  logic                                disp_gnt_vld,
   output logic                                running,
   output logic                                rtn_vld,
   output logic                                rcv_accept,
   output logic                                disp_accept,
   queue_port_if.ctrl                          q
);

   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      INIT     = 3'd1,
      READY    = 3'd2,
      RUNNING  = 3'd3,
      FINISHED = 3'd4
   } state_t;

   state_t                 state;
   state_t                 state_nxt;
   logic [8:0]             init_count;
   logic                   init_last;
   logic                   init_enq;
   logic                   busy;
   phold_pkg::event_word_u init_word;
   phold_pkg::event_word_u rcv_word;

   assign running = (state == RUNNING);

   // two cycles per initial event, enqueue on the even one
   assign init_last = ((init_count + 9'd1) >= {num_init_events, 1'b0});
   assign init_enq  = (state == INIT) && !busy && !init_count[0] &&
                      (init_count[8:1] < num_init_events) && !q.full;

   always_comb begin
      init_word               = '0;
      init_word.evt.target_lp = init_count[`PH_NB_LPID:1] & lp_mask;
      init_word.evt.live      = 1'b1;
   end

   assign rcv_word = core_evt_word[rcv_gnt_idx*`PH_MSG_WID +: `PH_MSG_WID];

   // receive wins over dispatch, neither right after a queue operation
   assign rcv_accept  = running && !busy && rcv_gnt_vld && !q.full;
   assign disp_accept = running && !busy && !rcv_accept && disp_gnt_vld && !q.empty;

   // null words get acked but are dropped here
   assign q.enq      = init_enq || (rcv_accept && (rcv_word != '0));
   assign q.enq_word = running ? rcv_word : init_word;
   assign q.deq      = disp_accept;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            state_nxt = INIT;
         end
         INIT: begin
            if (init_last) begin
               state_nxt = READY;
            end
         end
         READY: begin
            state_nxt = RUNNING;
         end
         RUNNING: begin
            if (gvt > sim_end) begin
               state_nxt = FINISHED;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= IDLE;
         init_count <= '0;
         busy       <= 1'b0;
         rtn_vld    <= 1'b0;
      end else begin
         state      <= state_nxt;
         init_count <= (state == INIT) ? init_count + 9'd1 : '0;
         busy       <= q.enq || q.deq || rcv_accept;
         // finish pulse, or overflow report while full
         rtn_vld    <= (running && (gvt > sim_end)) || q.full;
      end
   end

endmodule

// ==== logic/gvt_tracker.sv ====
`include "phold_consts.svh"

module gvt_tracker (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    running,
   input  logic [`PH_NUM_CORE-1:0] disp_onehot,
   input  logic [`PH_NUM_CORE-1:0] core_evt_ack,
   queue_port_if.monitor           q,
   output logic [`PH_TIME_WID-1:0] gvt
);

   logic [`PH_TIME_WID-1:0] core_time [`PH_NUM_CORE];
   logic [`PH_NUM_CORE-1:0] in_flight;
   logic [`PH_TIME_WID-1:0] min_time;
   logic                    min_vld;

   // time of the event each core is working on
   always_ff @(posedge clk) begin
      for (int i = 0; i < `PH_NUM_CORE; i++) begin
         if (disp_onehot[i]) begin
            core_time[i] <= q.head_word.evt.timestamp;
         end
      end
   end

   // busy from dispatch until the core's result is acked
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         in_flight <= '0;
      end else begin
         in_flight <= (in_flight | disp_onehot) & ~core_evt_ack;
      end
   end

   // lowest of queue head and in-flight times
   always_comb begin
      min_vld  = !q.empty;
      min_time = q.head_word.evt.timestamp;
      for (int i = 0; i < `PH_NUM_CORE; i++) begin
         if (in_flight[i] && (!min_vld || (core_time[i] < min_time))) begin
            min_vld  = 1'b1;
            min_time = core_time[i];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (running && min_vld) begin
         gvt <= min_time;
      end
   end

endmodule

// ==== logic/event_stats.sv ====
module event_stats (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          running,
   queue_port_if.monitor q,
   output logic [63:0]   total_cycles,
   output logic [63:0]   total_events,
   output logic [63:0]   total_antimsg
);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         total_cycles  <= '0;
         total_events  <= '0;
         total_antimsg <= '0;
      end else begin
         if (running) begin
            total_cycles <= total_cycles + 64'd1;
         end
         // every dequeue is one dispatched event
         if (q.deq) begin
            total_events <= total_events + 64'd1;
         end
         // head word still holds the dispatched event this cycle
         if (q.deq && !q.head_word.evt.live) begin
            total_antimsg <= total_antimsg + 64'd1;
         end
      end
   end

endmodule

// ==== logic/phold_engine.sv ====
`include "phold_consts.svh"

module phold_engine (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [`PH_TIME_WID-1:0]             sim_end,
   input  logic [7:0]                          num_init_events,
   input  logic [`PH_NB_LPID-1:0]              lp_mask,
   input  logic [`PH_NUM_CORE-1:0]             core_ready,
   input  logic [`PH_NUM_CORE-1:0]             core_evt_vld,
   input  logic [`PH_NUM_CORE*`PH_MSG_WID-1:0] core_evt_word,
   output logic [`PH_TIME_WID-1:0]             gvt,
   output logic                                rtn_vld,
   output logic [`PH_NUM_CORE-1:0]             disp_vld,
   output logic [`PH_MSG_WID-1:0]              disp_word,
   output logic [`PH_NUM_CORE-1:0]             core_evt_ack,
   output logic [63:0]                         total_cycles,
   output logic [63:0]                         total_events,
   output logic [63:0]                         total_antimsg
);

   logic                     running;
   logic                     rcv_accept;
   logic                     disp_accept;
   logic                     rcv_gnt_vld;
   logic [`PH_NB_COREID-1:0] rcv_gnt_idx;
   logic [`PH_NUM_CORE-1:0]  rcv_gnt_onehot;
   logic                     disp_gnt_vld;
   logic [`PH_NUM_CORE-1:0]  disp_gnt_onehot;

   queue_port_if qp ();

   // cores holding a new event
   rr_arbiter #(.NR(`PH_NUM_CORE)) i_rcv_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (core_evt_vld),
      .accept     (rcv_accept),
      .gnt_vld    (rcv_gnt_vld),
      .gnt_idx    (rcv_gnt_idx),
      .gnt_onehot (rcv_gnt_onehot)
   );

   // idle cores waiting for work, index not needed since disp_word is shared
   rr_arbiter #(.NR(`PH_NUM_CORE)) i_disp_arb (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (core_ready),
      .accept     (disp_accept),
      .gnt_vld    (disp_gnt_vld),
      .gnt_idx    (),
      .gnt_onehot (disp_gnt_onehot)
   );

   event_queue i_event_queue (
      .clk   (clk),
      .rst_n (rst_n),
      .q     (qp.queue)
   );

   sim_controller i_sim_controller (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .gvt             (gvt),
      .rcv_gnt_vld     (rcv_gnt_vld),
      .rcv_gnt_idx     (rcv_gnt_idx),
      .core_evt_word   (core_evt_word),
      .disp_gnt_vld    (disp_gnt_vld),
      .running         (running),
      .rtn_vld         (rtn_vld),
      .rcv_accept      (rcv_accept),
      .disp_accept     (disp_accept),
      .q               (qp.ctrl)
   );

   gvt_tracker i_gvt_tracker (
      .clk          (clk),
      .rst_n        (rst_n),
      .running      (running),
      .disp_onehot  (disp_vld),
      .core_evt_ack (core_evt_ack),
      .q            (qp.monitor),
      .gvt          (gvt)
   );

   event_stats i_event_stats (
      .clk           (clk),
      .rst_n         (rst_n),
      .running       (running),
      .q             (qp.monitor),
      .total_cycles  (total_cycles),
      .total_events  (total_events),
      .total_antimsg (total_antimsg)
   );

   // grants only count when the controller takes them
   assign core_evt_ack = rcv_gnt_onehot & {`PH_NUM_CORE{rcv_accept}};
   assign disp_vld     = disp_gnt_onehot & {`PH_NUM_CORE{disp_accept}};
   assign disp_word    = qp.head_word;

endmodule

// ==== tests/tb_phold_engine.sv ====
`include "phold_consts.svh"

module tb_phold_engine;

   localparam int TIMEOUT_CYC = 100;
   localparam int NUM_WAITS   = 64;
   localparam int WATCHDOG_NS = (NUM_WAITS * TIMEOUT_CYC + 500) * 10;
   localparam logic [15:0] SIM_END = 16'd1000;

   logic                                clk;
   logic                                rst_n;
   logic [`PH_TIME_WID-1:0]             sim_end;
   logic [7:0]                          num_init_events;
   logic [`PH_NB_LPID-1:0]              lp_mask;
   logic [`PH_NUM_CORE-1:0]             core_ready;
   logic [`PH_NUM_CORE-1:0]             core_evt_vld;
   logic [`PH_NUM_CORE*`PH_MSG_WID-1:0] core_evt_word;
   logic [`PH_TIME_WID-1:0]             gvt;
   logic                                rtn_vld;
   logic [`PH_NUM_CORE-1:0]             disp_vld;
   logic [`PH_MSG_WID-1:0]              disp_word;
   logic [`PH_NUM_CORE-1:0]             core_evt_ack;
   logic [63:0]                         total_cycles;
   logic [63:0]                         total_events;
   logic [63:0]                         total_antimsg;

   int          errors = 0;
   int          disp_cnt = 0;
   int          anti_cnt = 0;
   int          rtn_cnt = 0;
   bit          gvt_done = 0;
   logic [15:0] last_gvt = '0;
   // reference model of the words waiting in the queue
   phold_pkg::event_word_u ref_q [$];

   phold_engine i_phold_engine (.*);

   always #5 clk = ~clk;

   task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act) else begin
         errors++;
         $display("MISMATCH t=%0t %s exp %0h got %0h", $time, name, exp, act);
      end
   endtask

   // dispatch monitor, sampled away from the clock edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (disp_vld != '0) begin
            disp_cnt++;
            if (!disp_word[0]) begin
               anti_cnt++;
            end
            assert (disp_word != '0) else begin
               errors++;
               $display("null word was dispatched at t=%0t", $time);
            end
         end
         assert ($countones(core_evt_ack) <= 1) else begin
            errors++;
            $display("more than one core acked at t=%0t", $time);
         end
         if (rtn_vld) begin
            rtn_cnt++;
            gvt_done = 1;
         end
         if (!gvt_done) begin
            assert (gvt >= last_gvt) else begin
               errors++;
               $display("gvt went back from %0d to %0d at t=%0t", last_gvt, gvt, $time);
            end
            last_gvt = gvt;
         end
      end
   end

   task automatic take_dispatch(input int core, output phold_pkg::event_word_u w);
      int n;
      @(posedge clk);
      core_ready[core] <= 1'b1;
      n = 0;
      w = '0;
      do begin
         @(negedge clk);
         n++;
      end while (!disp_vld[core] && n < TIMEOUT_CYC);
      if (disp_vld[core]) begin
         w = disp_word;
      end else begin
         errors++;
         $display("no dispatch to core %0d at t=%0t", core, $time);
      end
      @(posedge clk);
      core_ready[core] <= 1'b0;
   endtask

   task automatic return_event(input int core, input logic [`PH_MSG_WID-1:0] w);
      int n;
      @(posedge clk);
      core_evt_vld[core] <= 1'b1;
      core_evt_word[core*`PH_MSG_WID +: `PH_MSG_WID] <= w;
      n = 0;
      do begin
         @(negedge clk);
         n++;
      end while (!core_evt_ack[core] && n < TIMEOUT_CYC);
      if (!core_evt_ack[core]) begin
         errors++;
         $display("core %0d was never acked at t=%0t", core, $time);
      end
      @(posedge clk);
      core_evt_vld[core] <= 1'b0;
   endtask

   function automatic phold_pkg::event_word_u make_word(input int lp, input int ts, input bit live);
      phold_pkg::event_word_u w;
      w.evt.target_lp = 6'(lp);
      w.evt.timestamp = 16'(ts);
      w.evt.live      = live;
      return w;
   endfunction

   // index of the smallest key in the reference queue
   function automatic int ref_min_idx();
      int m;
      m = 0;
      for (int i = 1; i < ref_q.size(); i++) begin
         if (ref_q[i].srt.sort_key < ref_q[m].srt.sort_key) begin
            m = i;
         end
      end
      return m;
   endfunction

   // dispatch to a core, compare with the smallest reference entry
   task automatic pop_and_check(input int core, output phold_pkg::event_word_u w);
      int m;
      take_dispatch(core, w);
      m = ref_min_idx();
      check_eq("disp_word.sort_key", 64'(ref_q[m].srt.sort_key), 64'(w.srt.sort_key));
      for (int i = 0; i < ref_q.size(); i++) begin
         if (ref_q[i] == w) begin
            m = i;
         end
      end
      check_eq("disp_word", 64'(ref_q[m]), 64'(w));
      ref_q.delete(m);
   endtask

   task automatic init_event_dispatch();
      int lp_cnt [64];
      int exp_cnt [64];
      phold_pkg::event_word_u w;
      lp_cnt  = '{default: 0};
      exp_cnt = '{default: 0};
      // initial event k goes to lp k under the mask
      for (int i = 0; i < 5; i++) begin
         exp_cnt[i & int'(lp_mask)]++;
      end
      for (int i = 0; i < 5; i++) begin
         take_dispatch(0, w);
         check_eq("disp_word.timestamp", 64'd0, 64'(w.evt.timestamp));
         check_eq("disp_word.live", 64'd1, 64'(w.evt.live));
         lp_cnt[w.evt.target_lp]++;
         // core 0 keeps its last event in flight, pinning gvt at 0
         if (i < 4) begin
            return_event(0, '0);
         end
      end
      for (int i = 0; i < 64; i++) begin
         check_eq($sformatf("lp%0d count", i), 64'(exp_cnt[i]), 64'(lp_cnt[i]));
      end
   endtask

   task automatic sorted_dispatch();
      phold_pkg::event_word_u w;
      logic [16:0] prev_key;
      int ts;
      ts = 0;
      for (int i = 0; i < 8; i++) begin
         // word 3 is an anti-message at the same time as live word 2
         if (i != 3) begin
            ts = 100 + $urandom % 200;
         end
         w = make_word($urandom % 64, ts, (i % 3) != 0);
         ref_q.push_back(w);
         return_event(1 + i % 3, w);
      end
      prev_key = '0;
      for (int i = 0; i < 8; i++) begin
         pop_and_check(1, w);
         assert (w.srt.sort_key >= prev_key) else begin
            errors++;
            $display("dispatch order broken at t=%0t", $time);
         end
         prev_key = w.srt.sort_key;
         return_event(1, '0);
      end
   endtask

   task automatic null_discard_rr();
      phold_pkg::event_word_u w;
      w = make_word(7, 600, 1'b1);
      ref_q.push_back(w);
      fork
         return_event(2, w);
         return_event(3, '0);
      join
   endtask

   task automatic gvt_follows_min();
      phold_pkg::event_word_u w;
      int m;
      for (int i = 0; i < 3; i++) begin
         w = make_word($urandom % 64, 500 + $urandom % 200, 1'b1);
         ref_q.push_back(w);
         return_event(2, w);
      end
      // all cores idle now
      return_event(0, '0);
      repeat (4) @(negedge clk);
      m = ref_min_idx();
      check_eq("gvt", 64'(ref_q[m].evt.timestamp), 64'(gvt));
      pop_and_check(3, w);
      repeat (4) begin
         @(negedge clk);
         assert (gvt <= w.evt.timestamp) else begin
            errors++;
            $display("gvt %0d above in-flight time %0d", gvt, w.evt.timestamp);
         end
      end
   endtask

   task automatic finish_and_stats();
      phold_pkg::event_word_u w;
      int n;
      check_eq("rtn_vld pulses before finish", 64'd0, 64'(rtn_cnt));
      while (ref_q.size() > 0) begin
         pop_and_check(0, w);
         return_event(0, make_word(1, 1500 + $urandom % 100, 1'b1));
      end
      return_event(3, make_word(2, 1600, 1'b1));
      n = 0;
      while (rtn_cnt == 0 && n < TIMEOUT_CYC) begin
         @(negedge clk);
         n++;
      end
      assert (rtn_cnt != 0) else begin
         errors++;
         $display("rtn_vld never pulsed after gvt passed sim_end");
      end
      assert (gvt > sim_end) else begin
         errors++;
         $display("rtn_vld pulsed while gvt %0d was not past sim_end", gvt);
      end
      // the controller restarts a few cycles later, so look only this far
      repeat (3) @(negedge clk);
      check_eq("rtn_vld pulses", 64'd1, 64'(rtn_cnt));
      check_eq("total_events", 64'(disp_cnt), total_events);
      check_eq("total_antimsg", 64'(anti_cnt), total_antimsg);
      assert (total_cycles != 0) else begin
         errors++;
         $display("total_cycles stayed at zero");
      end
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, tests did not complete");
      $display("errors: %0d", errors);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      void'($urandom(32'h9114));
      clk             = 1'b0;
      rst_n           = 1'b0;
      sim_end         = SIM_END;
      num_init_events = 8'd5;
      lp_mask         = 6'h03;
      core_ready      = '0;
      core_evt_vld    = '0;
      core_evt_word   = '0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      init_event_dispatch();
      sorted_dispatch();
      null_discard_rr();
      gvt_follows_min();
      finish_and_stats();
      $display("errors: %0d", errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+logic
logic/phold_pkg.sv
logic/queue_port_if.sv
logic/rr_arbiter.sv
logic/event_queue.sv
logic/sim_controller.sv
logic/gvt_tracker.sv
logic/event_stats.sv
logic/phold_engine.sv
tests/tb_phold_engine.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_phold_engine -o vsim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/vsim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
   exit 0
fi
exit 1
